/* source/board_params.svh */
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// board geometry
`define BOARD_SPOTS 32
`define FINAL_SPOT 31

// four players take turns
`define PLAYERS 4

// field widths
`define SPOT_W 5
`define DIE_W 3
`define STEP_W 4
`define SCORE_W 13

// points per pip on bonus and penalty spots
`define BONUS_UNIT 20

`endif

/* source/board_pkg.sv */
`default_nettype none

`include "board_params.svh"

package board_pkg;

	typedef logic [`SPOT_W-1:0] spot_t;
	typedef logic [`DIE_W-1:0] die_t;
	typedef logic [`STEP_W-1:0] step_t;
	typedef logic [`SCORE_W-1:0] score_t;
	typedef logic [$clog2(`PLAYERS)-1:0] player_t;

	// one bit per spot, set once collected
	typedef logic [`BOARD_SPOTS-1:0] progress_t;

	typedef enum logic [2:0] {
		KIND_NONE,
		KIND_PENALTY,
		KIND_BONUS,
		KIND_FIXED,
		KIND_COLLECT
	} spot_kind_e;

	typedef enum logic [1:0] {
		SEQ_READY,
		SEQ_BUSY,
		SEQ_GAME_OVER
	} seq_state_e;

endpackage

`default_nettype wire

/* source/turn_if.sv */
`default_nettype none

// dice result into the mover
interface roll_if;
	import board_pkg::*;
	logic valid;
	player_t player;
	step_t steps;
	die_t high_die;
	logic doubles;
	modport source (output valid, player, steps, high_die, doubles);
	modport sink (input valid, player, steps, high_die, doubles);
endinterface

// stop spot into scoring, progress_complete runs back to the mover
interface move_if;
	import board_pkg::*;
	logic valid;
	player_t player;
	spot_t spot;
	die_t high_die;
	logic doubles;
	logic finished;
	logic progress_complete;
	modport source (output valid, player, spot, high_die, doubles, finished,
		input progress_complete);
	modport sink (input valid, player, spot, high_die, doubles, finished,
		output progress_complete);
endinterface

// scored turn into the sequencer
interface score_if;
	import board_pkg::*;
	logic valid;
	player_t player;
	logic doubles;
	logic finished;
	score_t score;
	modport source (output valid, player, doubles, finished, score);
	modport sink (input valid, player, doubles, finished, score);
endinterface

`default_nettype wire

/* source/dice_latch.sv */
`default_nettype none

module dice_latch (
	input logic clk,
	input logic reset,
	input logic roll,
	input board_pkg::die_t die_a,
	input board_pkg::die_t die_b,
	input logic ready,
	input board_pkg::player_t player,
	roll_if.source roll_out
);
	import board_pkg::*;

	logic accept;
	die_t larger_die;

	// a roll only counts while the sequencer waits for one
	assign accept = roll && ready;
	assign larger_die = (die_a > die_b) ? die_a : die_b;

	always_ff @(posedge clk) begin
		if (!reset) begin
			roll_out.valid <= 1'b0;
		end else begin
			roll_out.valid <= accept;
		end
	end

	// turn data, held until the next accepted roll
	always_ff @(posedge clk) begin
		if (accept) begin
			roll_out.player <= player;
			roll_out.steps <= step_t'(die_a) + step_t'(die_b);
			roll_out.high_die <= larger_die;
			roll_out.doubles <= (die_a == die_b);
		end
	end

endmodule

`default_nettype wire

/* source/token_mover.sv */
`default_nettype none

`include "board_params.svh"

module token_mover (
	input logic clk,
	input logic reset,
	roll_if.sink roll_in,
	move_if.source move_out
);
	import board_pkg::*;

	spot_t spots [`PLAYERS];
	player_t cur_player;
	step_t remaining;
	die_t high_die;
	logic doubles;
	logic moving;
	spot_t next_spot;
	logic at_finish;

	// wraps from the last spot back to 0
	assign next_spot = spots[cur_player] + spot_t'(1);

	// finish only counts once every collect spot is taken
	assign at_finish = (next_spot == spot_t'(`FINAL_SPOT)) && move_out.progress_complete;

	assign move_out.player = cur_player;
	assign move_out.high_die = high_die;
	assign move_out.doubles = doubles;

	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int i = 0; i < `PLAYERS; i++) begin
				spots[i] <= '0;
			end
			moving <= 1'b0;
			remaining <= '0;
			move_out.valid <= 1'b0;
			move_out.spot <= '0;
			move_out.finished <= 1'b0;
		end else begin
			move_out.valid <= 1'b0;
			if (roll_in.valid) begin
				moving <= 1'b1;
				remaining <= roll_in.steps;
			end else if (moving) begin
				// one spot per cycle
				spots[cur_player] <= next_spot;
				remaining <= remaining - step_t'(1);
				if (remaining == step_t'(1) || at_finish) begin
					moving <= 1'b0;
					move_out.valid <= 1'b1;
					move_out.spot <= next_spot;
					move_out.finished <= at_finish;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (roll_in.valid) begin
			cur_player <= roll_in.player;
			high_die <= roll_in.high_die;
			doubles <= roll_in.doubles;
		end
	end

endmodule

`default_nettype wire

/* source/score_unit.sv */
`default_nettype none

`include "board_params.svh"

module score_unit (
	input logic clk,
	input logic reset,
	move_if.sink move_in,
	score_if.source score_out
);
	import board_pkg::*;

	score_t scores [`PLAYERS];
	progress_t progress [`PLAYERS];
	progress_t collect_mask;
	spot_kind_e kind;
	score_t points;
	score_t unit_pts;
	score_t cur_score;
	score_t new_score;
	logic collected;
	logic take;

	function automatic spot_kind_e spot_kind(input spot_t s);
		case (s)
			0, 8: return KIND_NONE;
			2, 30: return KIND_PENALTY;
			4, 12, 20, 28: return KIND_BONUS;
			16, 24: return KIND_FIXED;
			default: return KIND_COLLECT;
		endcase
	endfunction

	// base value of collect and fixed spots
	function automatic score_t spot_points(input spot_t s);
		case (s)
			1: return score_t'(5);
			3, 5: return score_t'(15);
			6, 21, 25: return score_t'(10);
			7, 9: return score_t'(20);
			10, 11, 26: return score_t'(30);
			13, 14, 17, 18, 19: return score_t'(40);
			15: return score_t'(50);
			16: return score_t'(150);
			22, 23, 27: return score_t'(60);
			24: return score_t'(300);
			29, 31: return score_t'(80);
			default: return '0;
		endcase
	endfunction

	always_comb begin
		for (int i = 0; i < `BOARD_SPOTS; i++) begin
			collect_mask[i] = (spot_kind(spot_t'(i)) == KIND_COLLECT);
		end
	end

	// fixed spots do not count toward completion
	assign move_in.progress_complete = &(progress[move_in.player] | ~collect_mask);

	assign kind = spot_kind(move_in.spot);
	assign points = spot_points(move_in.spot);
	assign cur_score = scores[move_in.player];
	assign collected = progress[move_in.player][move_in.spot];
	assign unit_pts = score_t'(`BONUS_UNIT) * score_t'(move_in.high_die);

	always_comb begin
		new_score = cur_score;
		take = 1'b0;
		if (!move_in.finished) begin
			case (kind)
				KIND_PENALTY: new_score = (cur_score > unit_pts) ? cur_score - unit_pts : '0;
				KIND_BONUS: new_score = cur_score + unit_pts;
				KIND_FIXED: begin
					if (!collected) begin
						new_score = cur_score + points;
						take = 1'b1;
					end
				end
				KIND_COLLECT: begin
					if (!collected) begin
						new_score = cur_score + points * score_t'(move_in.high_die);
						take = 1'b1;
					end
				end
				default: new_score = cur_score;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int i = 0; i < `PLAYERS; i++) begin
				scores[i] <= '0;
				progress[i] <= '0;
			end
			score_out.valid <= 1'b0;
			score_out.score <= '0;
		end else begin
			score_out.valid <= move_in.valid;
			if (move_in.valid) begin
				scores[move_in.player] <= new_score;
				score_out.score <= new_score;
				if (take) begin
					progress[move_in.player][move_in.spot] <= 1'b1;
				end
			end
		end
	end

	// turn data forwarded with the new score
	always_ff @(posedge clk) begin
		if (move_in.valid) begin
			score_out.player <= move_in.player;
			score_out.doubles <= move_in.doubles;
			score_out.finished <= move_in.finished;
		end
	end

endmodule

`default_nettype wire

/* source/turn_sequencer.sv */
`default_nettype none

`include "board_params.svh"

module turn_sequencer (
	input logic clk,
	input logic reset,
	input logic roll,
	score_if.sink score_in,
	output logic ready,
	output board_pkg::player_t player,
	output logic [`PLAYERS-1:0] finished_mask,
	output logic game_over
);
	import board_pkg::*;

	seq_state_e state;
	logic [`PLAYERS-1:0] done_mask;
	player_t next_player;

	// mask including the turn being scored
	always_comb begin
		done_mask = finished_mask;
		if (score_in.finished) begin
			done_mask[score_in.player] = 1'b1;
		end
	end

	// next unfinished player in order, doubles keep the turn
	always_comb begin
		player_t cand;
		logic found;
		next_player = score_in.player;
		found = 1'b0;
		for (int k = 1; k <= `PLAYERS; k++) begin
			cand = player_t'((int'(score_in.player) + k) % `PLAYERS);
			if (!found && !done_mask[cand]) begin
				next_player = cand;
				found = 1'b1;
			end
		end
		if (score_in.doubles && !done_mask[score_in.player]) begin
			next_player = score_in.player;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= SEQ_READY;
			player <= '0;
			finished_mask <= '0;
		end else begin
			case (state)
				SEQ_READY: begin
					// same condition the dice latch accepts on
					if (roll) begin
						state <= SEQ_BUSY;
					end
				end
				SEQ_BUSY: begin
					if (score_in.valid) begin
						finished_mask <= done_mask;
						if (&done_mask) begin
							state <= SEQ_GAME_OVER;
						end else begin
							state <= SEQ_READY;
							player <= next_player;
						end
					end
				end
				SEQ_GAME_OVER: state <= SEQ_GAME_OVER;
				default: state <= SEQ_READY;
			endcase
		end
	end

	assign ready = (state == SEQ_READY);
	assign game_over = (state == SEQ_GAME_OVER);

endmodule

`default_nettype wire

/* source/board_game_top.sv */
`default_nettype none

`include "board_params.svh"

module board_game_top (
	input logic clk,
	input logic reset,
	input logic roll,
	input board_pkg::die_t die_a,
	input board_pkg::die_t die_b,
	output logic ready,
	output board_pkg::player_t player,
	output board_pkg::spot_t spot,
	output board_pkg::score_t score,
	output logic score_valid,
	output logic [`PLAYERS-1:0] finished_mask,
	output logic game_over
);

	roll_if roll_bus ();
	move_if move_bus ();
	score_if score_bus ();

	dice_latch u_dice (
		.clk (clk),
		.reset (reset),
		.roll (roll),
		.die_a (die_a),
		.die_b (die_b),
		.ready (ready),
		.player (player),
		.roll_out (roll_bus)
	);

	token_mover u_mover (
		.clk (clk),
		.reset (reset),
		.roll_in (roll_bus),
		.move_out (move_bus)
	);

	score_unit u_score (
		.clk (clk),
		.reset (reset),
		.move_in (move_bus),
		.score_out (score_bus)
	);

	turn_sequencer u_seq (
		.clk (clk),
		.reset (reset),
		.roll (roll),
		.score_in (score_bus),
		.ready (ready),
		.player (player),
		.finished_mask (finished_mask),
		.game_over (game_over)
	);

	// results of the turn that just completed
	assign spot = move_bus.spot;
	assign score = score_bus.score;
	assign score_valid = score_bus.valid;

endmodule

`default_nettype wire

/* verif/tb_board_game_checks.svh */
`ifndef TB_BOARD_GAME_CHECKS_SVH
`define TB_BOARD_GAME_CHECKS_SVH

int error_count = 0;
int check_count = 0;
int test_count = 0;

task automatic check_player(input string name, input player_t exp, input player_t act);
	check_count++;
	if (act !== exp) begin
		error_count++;
		$display("** Error %s player: expected %0d, actual %0d", name, exp, act);
	end
endtask

task automatic check_spot(input string name, input spot_t exp, input spot_t act);
	check_count++;
	if (act !== exp) begin
		error_count++;
		$display("** Error %s spot: expected %0d, actual %0d", name, exp, act);
	end
endtask

task automatic check_score(input string name, input score_t exp, input score_t act);
	check_count++;
	if (act !== exp) begin
		error_count++;
		$display("** Error %s score: expected %0d, actual %0d", name, exp, act);
	end
endtask

task automatic check_mask(input string name, input logic [`PLAYERS-1:0] exp,
		input logic [`PLAYERS-1:0] act);
	check_count++;
	if (act !== exp) begin
		error_count++;
		$display("** Error %s finished_mask: expected %b, actual %b", name, exp, act);
	end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
	check_count++;
	if (act !== exp) begin
		error_count++;
		$display("** Error %s: expected %b, actual %b", name, exp, act);
	end
endtask

// score_valid pulses seen during one turn
task automatic check_pulses(input string name, input int exp, input int act);
	check_count++;
	if (act != exp) begin
		error_count++;
		$display("** Error %s score_valid pulses: expected %0d, actual %0d", name, exp, act);
	end
endtask

`endif

/* verif/tb_board_game.sv */
`default_nettype none

`include "board_params.svh"

module tb_board_game;
	import board_pkg::*;

	`include "tb_board_game_checks.svh"

	localparam int CLK_PERIOD = 10;
	localparam int TURN_LIMIT = 2000;
	localparam int NUM_DIRECTED = 18;
	localparam int CYCLES_PER_TURN = 20;
	localparam int WATCHDOG_CYCLES = (TURN_LIMIT + NUM_DIRECTED + 1) * CYCLES_PER_TURN;

	typedef struct packed {
		die_t a;
		die_t b;
		logic extra;
		player_t pl;
		spot_t sp;
		score_t sc;
	} turn_row_t;

	// dice, extra roll while busy, roller, stop spot, roller's new score
	turn_row_t turns [NUM_DIRECTED] = '{
		'{3'd1, 3'd3, 1'b0, 2'd0, 5'd4, 13'd60},
		'{3'd2, 3'd2, 1'b0, 2'd1, 5'd4, 13'd40},
		'{3'd6, 3'd6, 1'b0, 2'd1, 5'd16, 13'd190},
		'{3'd5, 3'd3, 1'b0, 2'd1, 5'd24, 13'd490},
		'{3'd1, 3'd1, 1'b0, 2'd2, 5'd2, 13'd0},
		'{3'd2, 3'd1, 1'b0, 2'd2, 5'd5, 13'd30},
		'{3'd6, 3'd1, 1'b0, 2'd3, 5'd7, 13'd120},
		'{3'd4, 3'd2, 1'b1, 2'd0, 5'd10, 13'd180},
		'{3'd5, 3'd1, 1'b0, 2'd1, 5'd30, 13'd390},
		'{3'd3, 3'd3, 1'b1, 2'd2, 5'd11, 13'd120},
		'{3'd6, 3'd4, 1'b0, 2'd2, 5'd21, 13'd180},
		'{3'd4, 3'd1, 1'b0, 2'd3, 5'd12, 13'd200},
		'{3'd2, 3'd4, 1'b0, 2'd0, 5'd16, 13'd330},
		'{3'd2, 3'd1, 1'b0, 2'd1, 5'd1, 13'd400},
		'{3'd2, 3'd1, 1'b0, 2'd2, 5'd24, 13'd480},
		'{3'd6, 3'd6, 1'b0, 2'd3, 5'd24, 13'd500},
		'{3'd6, 3'd6, 1'b0, 2'd3, 5'd4, 13'd620},
		'{3'd1, 3'd2, 1'b0, 2'd3, 5'd7, 13'd620}
	};

	logic clk = 1'b0;
	logic reset;
	logic roll;
	die_t die_a;
	die_t die_b;
	logic ready;
	player_t player;
	spot_t spot;
	score_t score;
	logic score_valid;
	logic [`PLAYERS-1:0] finished_mask;
	logic game_over;

	// reference model state
	spot_t m_spot [`PLAYERS];
	score_t m_score [`PLAYERS];
	progress_t m_prog [`PLAYERS];
	logic [`PLAYERS-1:0] m_done;
	player_t m_player;
	logic m_over;
	spot_t m_last_spot;
	score_t m_last_score;

	logic [31:0] lfsr = 32'heeca722d;

	board_game_top uut (
		.clk (clk),
		.reset (reset),
		.roll (roll),
		.die_a (die_a),
		.die_b (die_b),
		.ready (ready),
		.player (player),
		.spot (spot),
		.score (score),
		.score_valid (score_valid),
		.finished_mask (finished_mask),
		.game_over (game_over)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired, the DUT stopped finishing its turns");
		$display("Test FAILED");
		$finish;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end
		return s >> 1;
	endfunction

	// three bits per die, folded into 1 to 6
	function automatic die_t draw_die();
		logic [2:0] v;
		for (int i = 0; i < 3; i++) begin
			lfsr = lfsr_next(lfsr);
			v[i] = lfsr[0];
		end
		return die_t'((int'(v) % 6) + 1);
	endfunction

	function automatic spot_kind_e spot_class(input spot_t s);
		case (int'(s))
			0, 8: return KIND_NONE;
			2, 30: return KIND_PENALTY;
			4, 12, 20, 28: return KIND_BONUS;
			16, 24: return KIND_FIXED;
			default: return KIND_COLLECT;
		endcase
	endfunction

	function automatic int base_points(input spot_t s);
		case (int'(s))
			1: return 5;
			3, 5: return 15;
			6, 21, 25: return 10;
			7, 9: return 20;
			10, 11, 26: return 30;
			13, 14, 17, 18, 19: return 40;
			15: return 50;
			16: return 150;
			22, 23, 27: return 60;
			24: return 300;
			29, 31: return 80;
			default: return 0;
		endcase
	endfunction

	function automatic logic collect_complete(input progress_t p);
		for (int s = 0; s < `BOARD_SPOTS; s++) begin
			if (spot_class(spot_t'(s)) == KIND_COLLECT && !p[s]) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	task automatic model_reset();
		for (int i = 0; i < `PLAYERS; i++) begin
			m_spot[i] = '0;
			m_score[i] = '0;
			m_prog[i] = '0;
		end
		m_done = '0;
		m_player = '0;
		m_over = 1'b0;
	endtask

	task automatic model_turn(input die_t a, input die_t b);
		int steps;
		int hi;
		logic fin;
		spot_t pos;
		score_t cur;
		score_t unit;
		player_t p;
		player_t c;
		logic found;
		p = m_player;
		steps = int'(a) + int'(b);
		hi = (a > b) ? int'(a) : int'(b);
		pos = m_spot[p];
		fin = 1'b0;
		for (int i = 0; i < steps && !fin; i++) begin
			pos = spot_t'((int'(pos) + 1) % `BOARD_SPOTS);
			if (pos == spot_t'(`FINAL_SPOT) && collect_complete(m_prog[p])) begin
				fin = 1'b1;
			end
		end
		cur = m_score[p];
		unit = score_t'(`BONUS_UNIT * hi);
		if (!fin) begin
			case (spot_class(pos))
				KIND_PENALTY: cur = (cur > unit) ? cur - unit : '0;
				KIND_BONUS: cur = cur + unit;
				KIND_FIXED: begin
					if (!m_prog[p][pos]) begin
						cur = cur + score_t'(base_points(pos));
						m_prog[p][pos] = 1'b1;
					end
				end
				KIND_COLLECT: begin
					if (!m_prog[p][pos]) begin
						cur = cur + score_t'(base_points(pos) * hi);
						m_prog[p][pos] = 1'b1;
					end
				end
				default: cur = cur;
			endcase
		end
		m_spot[p] = pos;
		m_score[p] = cur;
		m_last_spot = pos;
		m_last_score = cur;
		if (fin) begin
			m_done[p] = 1'b1;
		end
		if (&m_done) begin
			m_over = 1'b1;
		end else if (a == b && !m_done[p]) begin
			m_player = p;
		end else begin
			found = 1'b0;
			for (int k = 1; k <= `PLAYERS; k++) begin
				c = player_t'((int'(p) + k) % `PLAYERS);
				if (!found && !m_done[c]) begin
					m_player = c;
					found = 1'b1;
				end
			end
		end
	endtask

	// one roll, optionally a second pulse while busy, until ready or game over
	task automatic play_turn(input die_t a, input die_t b, input logic extra,
			output int pulses, output spot_t got_spot, output score_t got_score);
		pulses = 0;
		got_spot = '0;
		got_score = '0;
		@(negedge clk);
		while (!ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		roll <= 1'b1;
		die_a <= a;
		die_b <= b;
		@(posedge clk);
		roll <= 1'b0;
		if (extra) begin
			@(posedge clk);
			roll <= 1'b1;
			@(posedge clk);
			roll <= 1'b0;
		end
		@(negedge clk);
		while (!ready && !game_over) begin
			if (score_valid) begin
				pulses++;
				got_spot = spot;
				got_score = score;
			end
			@(negedge clk);
		end
	endtask

	task automatic run_turn(input string name, input die_t a, input die_t b, input logic extra,
			input player_t exp_player, input spot_t exp_spot, input score_t exp_score);
		int errors_before;
		int pulses;
		spot_t got_spot;
		score_t got_score;
		errors_before = error_count;
		test_count++;
		check_player({name, " roller"}, exp_player, player);
		play_turn(a, b, extra, pulses, got_spot, got_score);
		check_pulses(name, 1, pulses);
		check_spot(name, exp_spot, got_spot);
		check_score(name, exp_score, got_score);
		check_player({name, " next"}, m_player, player);
		check_mask(name, m_done, finished_mask);
		check_flag({name, " game_over"}, m_over, game_over);
		check_flag({name, " ready"}, !m_over, ready);
		$display("%s: %s", name, (error_count == errors_before) ? "ok" : "mismatch");
	endtask

	initial begin
		die_t a;
		die_t b;
		player_t p;
		int random_turns;
		reset = 1'b0;
		roll = 1'b0;
		die_a = 3'd1;
		die_b = 3'd1;
		random_turns = 0;
		model_reset();
		repeat (4) @(posedge clk);
		reset <= 1'b1;

		@(negedge clk);
		test_count++;
		check_flag("reset ready", 1'b1, ready);
		check_player("reset", '0, player);
		check_mask("reset", '0, finished_mask);
		check_flag("reset game_over", 1'b0, game_over);
		$display("reset: %s", (error_count == 0) ? "ok" : "mismatch");

		for (int i = 0; i < NUM_DIRECTED; i++) begin
			model_turn(turns[i].a, turns[i].b);
			run_turn($sformatf("directed %0d", i), turns[i].a, turns[i].b, turns[i].extra,
				turns[i].pl, turns[i].sp, turns[i].sc);
		end

		// random game played to the end
		for (int t = 0; t < TURN_LIMIT && !m_over && !game_over; t++) begin
			a = draw_die();
			b = draw_die();
			p = m_player;
			model_turn(a, b);
			run_turn($sformatf("random %0d", t), a, b, 1'b0, p, m_last_spot, m_last_score);
			random_turns++;
		end
		check_flag("random run game_over", 1'b1, game_over);
		$display("random run: %0d turns, finished_mask %b, game_over %b",
			random_turns, finished_mask, game_over);

		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+source
+incdir+verif
source/board_pkg.sv
source/turn_if.sv
source/dice_latch.sv
source/token_mover.sv
source/score_unit.sv
source/turn_sequencer.sv
source/board_game_top.sv
verif/tb_board_game.sv

/* build.sh */
#!/usr/bin/env bash
# build and run the board game simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tb_board_game -o sim_board_game
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

output=$(./obj_dir/sim_board_game)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
	exit 0
fi
exit 1
